//--- design/fsync_pkg.sv
/*
 * Shared sizes and types of the 4x4 barrier network.
 * Levels 1 to 4 stay inside the tile; level 5 leaves it through the root.
 * CU index is GRID_DIM * row + column.
 */

package fsync_pkg;

  localparam int unsigned GRID_DIM      = 4;
  localparam int unsigned N_CU          = GRID_DIM * GRID_DIM;
  localparam int unsigned N_TREE_LEVELS = 4;

  // Barrier level, values 1 to 5 are meaningful and 0 is never sent
  typedef logic [2:0] lvl_t;

  typedef logic [$clog2(N_CU)-1:0] cu_idx_t;

  localparam lvl_t LVL_OFF_TILE = lvl_t'(N_TREE_LEVELS + 1);

  // A node is either gathering its two children or waiting for its parent
  typedef enum logic {
    NODE_COLLECT,
    NODE_WAIT_PARENT
  } node_state_e;

  // Index of the CU at a given grid position
  function automatic cu_idx_t cu_at(input int unsigned row, input int unsigned col);
    return cu_idx_t'(GRID_DIM * row + col);
  endfunction

endpackage

//--- design/fsync_node.sv
/*
 * Binary barrier node. Both children must request the same level, and a
 * child does not request again until it has been woken.
 * Every decision adds exactly one register stage.
 */

`timescale 1ns/1ps

module fsync_node #(
  parameter int unsigned NODE_LVL = 1
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,

  input  logic [1:0]            child_req_i,
  input  fsync_pkg::lvl_t [1:0] child_lvl_i,
  output logic [1:0]            child_wake_o,
  output fsync_pkg::lvl_t       child_wake_lvl_o,

  output logic                  up_req_o,
  output fsync_pkg::lvl_t       up_lvl_o,
  input  logic                  up_wake_i,
  input  fsync_pkg::lvl_t       up_wake_lvl_i
);

  import fsync_pkg::*;

  node_state_e state_q;
  node_state_e state_d;
  logic [1:0]  arrived_q;
  logic [1:0]  arrived_d;
  lvl_t        lvl_q;
  lvl_t        cur_lvl;
  logic        all_in;
  logic        own_done;
  logic        fwd_up;
  logic        relay;

  always_comb begin
    // A request seen this cycle carries the level, otherwise use the stored one
    if (child_req_i[0]) begin
      cur_lvl = child_lvl_i[0];
    end else if (child_req_i[1]) begin
      cur_lvl = child_lvl_i[1];
    end else begin
      cur_lvl = lvl_q;
    end

    arrived_d = arrived_q | child_req_i;

    // Completion is only decided while collecting
    all_in   = (state_q == NODE_COLLECT) && (&arrived_d);
    own_done = all_in && (cur_lvl == lvl_t'(NODE_LVL));
    fwd_up   = all_in && !own_done;
    relay    = (state_q == NODE_WAIT_PARENT) && up_wake_i;

    if (all_in) begin
      arrived_d = '0;
    end

    state_d = state_q;
    if (fwd_up) begin
      state_d = NODE_WAIT_PARENT;
    end else if (relay) begin
      state_d = NODE_COLLECT;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q      <= NODE_COLLECT;
      arrived_q    <= '0;
      child_wake_o <= '0;
      up_req_o     <= 1'b0;
    end else begin
      state_q      <= state_d;
      arrived_q    <= arrived_d;
      child_wake_o <= (own_done || relay) ? 2'b11 : 2'b00;
      up_req_o     <= fwd_up;
    end
  end

  // Level payload, only meaningful alongside its strobe
  always_ff @(posedge clk_i) begin
    lvl_q <= cur_lvl;
    if (own_done) begin
      child_wake_lvl_o <= cur_lvl;
    end else if (relay) begin
      child_wake_lvl_o <= up_wake_lvl_i;
    end
    if (fwd_up) begin
      up_lvl_o <= cur_lvl;
    end
  end

endmodule

//--- design/fsync_nbr_node.sv
/*
 * Two-CU neighbor barrier. Each CU sends one pulse per barrier and waits
 * for its wake before sending another.
 */

`timescale 1ns/1ps

module fsync_nbr_node (
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic [1:0] req_i,
  output logic [1:0] wake_o
);

  logic [1:0] arrived_q;
  logic [1:0] arrived_d;
  logic       both_in;

  always_comb begin
    arrived_d = arrived_q | req_i;
    both_in   = &arrived_d;
    // Flags clear in the cycle the wake is registered
    if (both_in) begin
      arrived_d = '0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      arrived_q <= '0;
      wake_o    <= '0;
    end else begin
      arrived_q <= arrived_d;
      wake_o    <= both_in ? 2'b11 : 2'b00;
    end
  end

endmodule

//--- design/fsync_4x4.sv
/*
 * Barrier network for a 4x4 CU grid with one request port per CU.
 * Level-5 barriers leave on sync_out_o and return on wake_in_i.
 * Only the eight neighbor pairs across quad boundaries are active.
 */

`timescale 1ns/1ps

module fsync_4x4 (
  input  logic                                  clk_i,
  input  logic                                  rst_n_i,

  input  logic [fsync_pkg::N_CU-1:0]            sync_req_i,
  input  fsync_pkg::lvl_t [fsync_pkg::N_CU-1:0] sync_lvl_i,
  output logic [fsync_pkg::N_CU-1:0]            wake_o,
  output fsync_pkg::lvl_t [fsync_pkg::N_CU-1:0] wake_lvl_o,

  input  logic [fsync_pkg::N_CU-1:0]            nbr_h_req_i,
  input  logic [fsync_pkg::N_CU-1:0]            nbr_v_req_i,
  output logic [fsync_pkg::N_CU-1:0]            nbr_h_wake_o,
  output logic [fsync_pkg::N_CU-1:0]            nbr_v_wake_o,

  output logic                                  sync_out_o,
  input  logic                                  wake_in_i
);

  import fsync_pkg::*;

  // Upward strobes and levels of each tree level
  logic [N_CU/2-1:0] l1_up_req;
  lvl_t [N_CU/2-1:0] l1_up_lvl;
  logic [N_CU/4-1:0] l2_up_req;
  lvl_t [N_CU/4-1:0] l2_up_lvl;
  logic [N_CU/8-1:0] l3_up_req;
  lvl_t [N_CU/8-1:0] l3_up_lvl;

  // Wakes that each parent hands to its two children
  lvl_t [N_CU/2-1:0] l1_wake_lvl;
  logic [1:0]        l2_cwake [N_CU/4];
  lvl_t              l2_cwlvl [N_CU/4];
  logic [1:0]        l3_cwake [N_CU/8];
  lvl_t              l3_cwlvl [N_CU/8];
  logic [1:0]        root_cwake;
  lvl_t              root_cwlvl;

  logic [1:0]        h_nbr_wake [GRID_DIM];
  logic [1:0]        v_nbr_wake [GRID_DIM];

  // Level 1 node n serves the horizontal pair at row n/2, columns 2*(n%2) and one more.
  // Its parent is quad (n/4)*2 + n%2, in slot (n/2)%2
  for (genvar n = 0; n < N_CU/2; n++) begin : gen_l1
    fsync_node #(
      .NODE_LVL (1)
    ) i_node (
      .clk_i            (clk_i),
      .rst_n_i          (rst_n_i),
      .child_req_i      (sync_req_i[cu_at(n/2, 2*(n%2)) +: 2]),
      .child_lvl_i      (sync_lvl_i[cu_at(n/2, 2*(n%2)) +: 2]),
      .child_wake_o     (wake_o[cu_at(n/2, 2*(n%2)) +: 2]),
      .child_wake_lvl_o (l1_wake_lvl[n]),
      .up_req_o         (l1_up_req[n]),
      .up_lvl_o         (l1_up_lvl[n]),
      .up_wake_i        (l2_cwake[(n/4)*2 + n%2][(n/2)%2]),
      .up_wake_lvl_i    (l2_cwlvl[(n/4)*2 + n%2])
    );

    assign wake_lvl_o[cu_at(n/2, 2*(n%2))]     = l1_wake_lvl[n];
    assign wake_lvl_o[cu_at(n/2, 2*(n%2)) + 1] = l1_wake_lvl[n];
  end

  // Quad q stacks the level-1 nodes of two adjacent rows
  for (genvar q = 0; q < N_CU/4; q++) begin : gen_l2
    fsync_node #(
      .NODE_LVL (2)
    ) i_node (
      .clk_i            (clk_i),
      .rst_n_i          (rst_n_i),
      .child_req_i      ({l1_up_req[(q/2)*4 + q%2 + 2], l1_up_req[(q/2)*4 + q%2]}),
      .child_lvl_i      ({l1_up_lvl[(q/2)*4 + q%2 + 2], l1_up_lvl[(q/2)*4 + q%2]}),
      .child_wake_o     (l2_cwake[q]),
      .child_wake_lvl_o (l2_cwlvl[q]),
      .up_req_o         (l2_up_req[q]),
      .up_lvl_o         (l2_up_lvl[q]),
      .up_wake_i        (l3_cwake[q/2][q%2]),
      .up_wake_lvl_i    (l3_cwlvl[q/2])
    );
  end

  // Half grid h joins the two quads side by side in rows 2h and 2h+1
  for (genvar h = 0; h < N_CU/8; h++) begin : gen_l3
    fsync_node #(
      .NODE_LVL (3)
    ) i_node (
      .clk_i            (clk_i),
      .rst_n_i          (rst_n_i),
      .child_req_i      (l2_up_req[2*h +: 2]),
      .child_lvl_i      (l2_up_lvl[2*h +: 2]),
      .child_wake_o     (l3_cwake[h]),
      .child_wake_lvl_o (l3_cwlvl[h]),
      .up_req_o         (l3_up_req[h]),
      .up_lvl_o         (l3_up_lvl[h]),
      .up_wake_i        (root_cwake[h]),
      .up_wake_lvl_i    (root_cwlvl)
    );
  end

  // The root forwards only level-5 barriers, so the outgoing level is implied
  fsync_node #(
    .NODE_LVL (N_TREE_LEVELS)
  ) i_root (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .child_req_i      (l3_up_req),
    .child_lvl_i      (l3_up_lvl),
    .child_wake_o     (root_cwake),
    .child_wake_lvl_o (root_cwlvl),
    .up_req_o         (sync_out_o),
    .up_lvl_o         (),
    .up_wake_i        (wake_in_i),
    .up_wake_lvl_i    (LVL_OFF_TILE)
  );

  // Horizontal pairs sit at columns 1 and 2 of each row,
  // vertical pairs at rows 1 and 2 of each column
  for (genvar i = 0; i < GRID_DIM; i++) begin : gen_nbr
    fsync_nbr_node i_h_nbr (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .req_i   ({nbr_h_req_i[cu_at(i, 2)], nbr_h_req_i[cu_at(i, 1)]}),
      .wake_o  (h_nbr_wake[i])
    );

    fsync_nbr_node i_v_nbr (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .req_i   ({nbr_v_req_i[cu_at(2, i)], nbr_v_req_i[cu_at(1, i)]}),
      .wake_o  (v_nbr_wake[i])
    );
  end

  // Ports outside the active pairs never wake
  always_comb begin
    nbr_h_wake_o = '0;
    nbr_v_wake_o = '0;
    for (int i = 0; i < GRID_DIM; i++) begin
      nbr_h_wake_o[cu_at(i, 1)] = h_nbr_wake[i][0];
      nbr_h_wake_o[cu_at(i, 2)] = h_nbr_wake[i][1];
      nbr_v_wake_o[cu_at(1, i)] = v_nbr_wake[i][0];
      nbr_v_wake_o[cu_at(2, i)] = v_nbr_wake[i][1];
    end
  end

endmodule

//--- sim/tb_clk_gen.sv
/*
 * Free-running testbench clock and active-low reset.
 * Reset is released on a rising edge after RST_CYCLES cycles.
 */

`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int unsigned PERIOD_NS  = 10,
  parameter int unsigned RST_CYCLES = 4
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

//--- sim/fsync_4x4_checker.sv
/*
 * Assertions bound into the barrier network top.
 * Level agreement is tracked per level-1 pair and assumes one open
 * barrier per CU at a time.
 */

`timescale 1ns/1ps

module fsync_4x4_checker (
  input  logic                                  clk_i,
  input  logic                                  rst_n_i,
  input  logic [fsync_pkg::N_CU-1:0]            sync_req_i,
  input  fsync_pkg::lvl_t [fsync_pkg::N_CU-1:0] sync_lvl_i,
  input  logic [fsync_pkg::N_CU-1:0]            wake_i,
  input  logic [fsync_pkg::N_CU-1:0]            nbr_h_wake_i,
  input  logic [fsync_pkg::N_CU-1:0]            nbr_v_wake_i,
  input  logic                                  sync_out_i
);

  import fsync_pkg::*;

  logic [N_CU-1:0] h_active;
  logic [N_CU-1:0] v_active;

  // Active neighbor ports sit on either side of the quad boundaries
  always_comb begin
    h_active = '0;
    v_active = '0;
    for (int i = 0; i < GRID_DIM; i++) begin
      h_active[cu_at(i, 1)] = 1'b1;
      h_active[cu_at(i, 2)] = 1'b1;
      v_active[cu_at(1, i)] = 1'b1;
      v_active[cu_at(2, i)] = 1'b1;
    end
  end

  a_sync_out_single: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    sync_out_i |=> !sync_out_i)
    else $error("sync_out_o stayed high for two cycles");

  a_wake_single: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (wake_i & $past(wake_i)) == '0)
    else $error("a wake_o bit stayed high for two cycles");

  a_nbr_inactive: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ((nbr_h_wake_i & ~h_active) == '0) && ((nbr_v_wake_i & ~v_active) == '0))
    else $error("neighbor wake on an inactive port");

  // Level-1 node n serves CUs 2n and 2n+1
  for (genvar n = 0; n < N_CU/2; n++) begin : gen_pair
    logic [1:0] req;
    lvl_t       lvl_a;
    lvl_t       lvl_b;
    logic       open_q;
    lvl_t       first_lvl_q;

    assign req   = sync_req_i[2*n +: 2];
    assign lvl_a = sync_lvl_i[2*n];
    assign lvl_b = sync_lvl_i[2*n+1];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
        open_q      <= 1'b0;
        first_lvl_q <= '0;
      end else if (req == 2'b11) begin
        open_q <= 1'b0;
      end else if (req != 2'b00) begin
        open_q <= !open_q;
        if (!open_q) begin
          first_lvl_q <= req[0] ? lvl_a : lvl_b;
        end
      end
    end

    a_pair_same: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (req == 2'b11) |-> (lvl_a == lvl_b))
      else $error("level-1 pair %0d requested two different levels", n);

    a_pair_second: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      ($onehot(req) && open_q) |-> ((req[0] ? lvl_a : lvl_b) == first_lvl_q))
      else $error("level-1 pair %0d second request has another level", n);
  end

endmodule

//--- sim/tb_fsync_4x4.sv
/*
 * Testbench for the 4x4 barrier network. Each CU keeps at most one open
 * barrier per port, so the monitor tracks one request per CU and port.
 * Expected wakes come from the group rule and the 2L-1 cycle latency.
 */

`timescale 1ns/1ps

module tb_fsync_4x4;

  import fsync_pkg::*;

  localparam int unsigned RST_CYCLES      = 4;
  localparam int unsigned N_TESTS         = 5;
  localparam int unsigned CYCLES_PER_TEST = 200;
  localparam int unsigned LIMIT_NS        = (RST_CYCLES + CYCLES_PER_TEST * N_TESTS) * 10;

  logic            clk;
  logic            rst_n;
  logic [N_CU-1:0] sync_req;
  lvl_t [N_CU-1:0] sync_lvl;
  logic [N_CU-1:0] wake;
  lvl_t [N_CU-1:0] wake_lvl;
  logic [N_CU-1:0] nbr_h_req;
  logic [N_CU-1:0] nbr_v_req;
  logic [N_CU-1:0] nbr_h_wake;
  logic [N_CU-1:0] nbr_v_wake;
  logic            sync_out;
  logic            wake_in;

  int              seed;
  int              cyc         = 0;
  int              out_cnt     = 0;
  int              wake_in_cyc = -1000;
  string           test_name   = "reset idle";
  // Open tree barriers and neighbor barriers (index 0 horizontal, 1 vertical)
  logic [N_CU-1:0] pend        = '0;
  int              req_cyc [N_CU];
  lvl_t            req_lvl [N_CU];
  logic [N_CU-1:0] nbr_pend [2] = '{default: '0};
  int              nbr_cyc [2][N_CU];

  tb_clk_gen #(
    .PERIOD_NS  (10),
    .RST_CYCLES (RST_CYCLES)
  ) i_clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  fsync_4x4 uut (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .sync_req_i   (sync_req),
    .sync_lvl_i   (sync_lvl),
    .wake_o       (wake),
    .wake_lvl_o   (wake_lvl),
    .nbr_h_req_i  (nbr_h_req),
    .nbr_v_req_i  (nbr_v_req),
    .nbr_h_wake_o (nbr_h_wake),
    .nbr_v_wake_o (nbr_v_wake),
    .sync_out_o   (sync_out),
    .wake_in_i    (wake_in)
  );

  bind fsync_4x4 fsync_4x4_checker i_checker (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .sync_req_i   (sync_req_i),
    .sync_lvl_i   (sync_lvl_i),
    .wake_i       (wake_o),
    .nbr_h_wake_i (nbr_h_wake_o),
    .nbr_v_wake_i (nbr_v_wake_o),
    .sync_out_i   (sync_out_o)
  );

  // CUs that a level-L barrier started by this CU wakes
  function automatic logic [N_CU-1:0] wake_set(input int cu, input int lvl);
    logic [N_CU-1:0] set;
    int r;
    int c;
    int rj;
    int cj;
    r = cu / GRID_DIM;
    c = cu % GRID_DIM;
    for (int j = 0; j < N_CU; j++) begin
      rj = j / GRID_DIM;
      cj = j % GRID_DIM;
      case (lvl)
        1:       set[j] = (rj == r) && (cj / 2 == c / 2);
        2:       set[j] = (rj / 2 == r / 2) && (cj / 2 == c / 2);
        3:       set[j] = (rj / 2 == r / 2);
        default: set[j] = 1'b1;
      endcase
    end
    return set;
  endfunction

  // Partner across a quad boundary, or -1 for an inactive port
  function automatic int nbr_partner(input int dir, input int cu);
    int pos;
    pos = (dir == 0) ? cu % GRID_DIM : cu / GRID_DIM;
    if (pos == 1) begin
      return (dir == 0) ? cu + 1 : cu + GRID_DIM;
    end else if (pos == 2) begin
      return (dir == 0) ? cu - 1 : cu - GRID_DIM;
    end
    return -1;
  endfunction

  function automatic logic [N_CU-1:0] nbr_active(input int dir);
    logic [N_CU-1:0] mask;
    for (int i = 0; i < N_CU; i++) begin
      mask[i] = (nbr_partner(dir, i) >= 0);
    end
    return mask;
  endfunction

  function automatic int last_req(input logic [N_CU-1:0] mask);
    int last;
    last = -1;
    for (int i = 0; i < N_CU; i++) begin
      if (mask[i] && req_cyc[i] > last) begin
        last = req_cyc[i];
      end
    end
    return last;
  endfunction

  task automatic fail_run(input string msg);
    $display("Failure in test %s: %s", test_name, msg);
    $display("Result: FAILED");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic check_val(input string what, input int expected, input int actual);
    if (expected != actual) begin
      $display("** Error [%s] %s: expected %0d, actual %0d", test_name, what, expected,
               actual);
      fail_run("value mismatch");
    end
  endtask

  // Pulses each CU in the mask once, at a random offset of 0 to 7 cycles
  task automatic issue(input int port, input logic [N_CU-1:0] mask, input int lvl);
    int              offs [N_CU];
    int              max_off;
    logic [N_CU-1:0] vec;
    max_off = 0;
    for (int i = 0; i < N_CU; i++) begin
      offs[i] = $unsigned($random(seed)) % 8;
      if (mask[i] && offs[i] > max_off) begin
        max_off = offs[i];
      end
    end
    for (int t = 0; t <= max_off; t++) begin
      @(posedge clk);
      for (int i = 0; i < N_CU; i++) begin
        vec[i] = mask[i] && (offs[i] == t);
      end
      case (port)
        0: begin
          sync_req <= vec;
          sync_lvl <= {N_CU{lvl_t'(lvl)}};
        end
        1:       nbr_h_req <= vec;
        default: nbr_v_req <= vec;
      endcase
    end
    @(posedge clk);
    sync_req  <= '0;
    nbr_h_req <= '0;
    nbr_v_req <= '0;
  endtask

  task automatic wait_idle();
    do begin
      @(posedge clk);
    end while (pend != '0 || nbr_pend[0] != '0 || nbr_pend[1] != '0);
  endtask

  task automatic track_nbr(input int dir, input logic [N_CU-1:0] req_v,
                           input logic [N_CU-1:0] wake_v);
    int p;
    int last;
    for (int i = 0; i < N_CU; i++) begin
      if (wake_v[i]) begin
        p = nbr_partner(dir, i);
        if (p < 0) begin
          fail_run($sformatf("neighbor wake on the inactive port of CU %0d", i));
        end else begin
          last = (nbr_cyc[dir][i] > nbr_cyc[dir][p]) ? nbr_cyc[dir][i] : nbr_cyc[dir][p];
          check_val($sformatf("CU %0d neighbor pair open", i), 1,
                    int'(nbr_pend[dir][i] & nbr_pend[dir][p]));
          check_val($sformatf("CU %0d neighbor wake cycle", i), last + 1, cyc);
        end
      end
    end
    nbr_pend[dir] = nbr_pend[dir] & ~wake_v;
    for (int i = 0; i < N_CU; i++) begin
      if (req_v[i] && nbr_partner(dir, i) >= 0) begin
        nbr_pend[dir][i] = 1'b1;
        nbr_cyc[dir][i]  = cyc;
      end
    end
  endtask

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  // Outputs are sampled on the falling edge, half a cycle after they change
  always @(negedge clk) begin : compare_proc
    logic [N_CU-1:0] grp;
    int              exp_cyc;
    if (rst_n) begin
      if (wake_in) begin
        wake_in_cyc = cyc;
      end
      if (sync_out) begin
        out_cnt++;
        check_val("all CUs open at sync_out_o", 1, int'(&pend));
        check_val("sync_out_o cycle", last_req(pend) + 4, cyc);
      end
      for (int i = 0; i < N_CU; i++) begin
        if (wake[i]) begin
          check_val($sformatf("CU %0d open barrier", i), 1, int'(pend[i]));
          grp = wake_set(i, int'(req_lvl[i]));
          check_val($sformatf("CU %0d group complete", i), 1, int'((pend & grp) == grp));
          if (req_lvl[i] == LVL_OFF_TILE) begin
            exp_cyc = wake_in_cyc + 4;
          end else begin
            exp_cyc = last_req(grp) + 2 * int'(req_lvl[i]) - 1;
          end
          check_val($sformatf("CU %0d wake cycle", i), exp_cyc, cyc);
          check_val($sformatf("CU %0d wake level", i), int'(req_lvl[i]), int'(wake_lvl[i]));
        end
      end
      pend = pend & ~wake;
      for (int i = 0; i < N_CU; i++) begin
        if (sync_req[i]) begin
          pend[i]    = 1'b1;
          req_cyc[i] = cyc;
          req_lvl[i] = sync_lvl[i];
        end
      end
      track_nbr(0, nbr_h_req, nbr_h_wake);
      track_nbr(1, nbr_v_req, nbr_v_wake);
    end
  end

  initial begin : watchdog
    #(LIMIT_NS);
    fail_run("watchdog expired before the tests completed");
  end

  initial begin : stimulus
    int delay;
    seed      = 32'hf34e_b52b;
    sync_req  = '0;
    sync_lvl  = '0;
    nbr_h_req = '0;
    nbr_v_req = '0;
    wake_in   = 1'b0;
    @(posedge rst_n);
    repeat (20) begin
      @(negedge clk);
      check_val("wake_o while idle", 0, int'(wake));
      check_val("neighbor wakes while idle", 0, int'(nbr_h_wake | nbr_v_wake));
      check_val("sync_out_o while idle", 0, int'(sync_out));
    end

    test_name = "level 1";
    issue(0, '1, 1);
    wait_idle();

    // Quads at CUs 2 and 8 run in flight together
    test_name = "levels 2 to 4";
    issue(0, wake_set(0, 2), 2);
    wait_idle();
    issue(0, wake_set(2, 2) | wake_set(8, 2), 2);
    wait_idle();
    issue(0, wake_set(10, 2), 2);
    wait_idle();
    issue(0, '1, 3);
    wait_idle();
    issue(0, '1, 4);
    wait_idle();

    test_name = "level 5";
    issue(0, '1, 5);
    while (out_cnt == 0) begin
      @(posedge clk);
    end
    delay = 1 + $unsigned($random(seed)) % 8;
    repeat (delay) @(posedge clk);
    wake_in <= 1'b1;
    @(posedge clk);
    wake_in <= 1'b0;
    wait_idle();
    check_val("sync_out_o pulses", 1, out_cnt);

    test_name = "neighbor";
    issue(1, ~nbr_active(0), 0);
    issue(2, ~nbr_active(1), 0);
    repeat (10) @(posedge clk);
    issue(1, nbr_active(0), 0);
    wait_idle();
    issue(2, nbr_active(1), 0);
    wait_idle();

    $display("Result: PASSED");
    $finish;
  end

endmodule

//--- verilog.f
design/fsync_pkg.sv
design/fsync_node.sv
design/fsync_nbr_node.sv
design/fsync_4x4.sv
sim/tb_clk_gen.sv
sim/fsync_4x4_checker.sv
sim/tb_fsync_4x4.sv

//--- run.sh
#!/bin/sh
# Builds and runs the barrier network testbench with Verilator.
# The exit status is the simulator's, so a failed run returns non-zero.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module tb_fsync_4x4 -f verilog.f -o tb_fsync_4x4
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit "$status"
fi

./obj_dir/tb_fsync_4x4
status=$?
if [ "$status" -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit "$status"
fi

exit 0
